//--- Makefile
# Verilator build and run of the dual fetch front end testbench

VERILATOR ?= verilator
TOP       ?= dualFetchTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+verilog
+incdir+verif
verilog/riscvPkg.sv
verilog/predictorPkg.sv
verilog/predictorIf.sv
verilog/fetchSlot.sv
verilog/resolveUnit.sv
verilog/updateArbiter.sv
verilog/predictorTables.sv
verilog/dualFetchTop.sv
verif/dualFetchTb.sv

//--- verif/dualFetchModel.svh
/*
 * Cycle model of the dual fetch front end, advanced once per clock
 */
`ifndef DUAL_FETCH_MODEL_SVH
`define DUAL_FETCH_MODEL_SVH

// Resolve group of one slot, as the execute stage reports it
typedef struct packed {
    logic valid;
    addrT pc;
    logic isBranch;
    logic isJump;
    logic taken;
    addrT target;
    logic predTaken;
    phtIdxT phtIdx;
} resolveT;

addrT mPc [2];
phtIdxT mGhr [2];
logic mBufValid [2];
resolveT mBuf [2];
logic mLastGrant;
btbEntryT mBtb [`BTB_ENTRIES];
counterT mPht [`BTB_ENTRIES];

function automatic void resetModel();
    mPc[0] = `RESET_PC0;
    mPc[1] = `RESET_PC1;
    mGhr[0] = '0;
    mGhr[1] = '0;
    mBufValid[0] = 1'b0;
    mBufValid[1] = 1'b0;
    // Slot 1 counts as last owner, slot 0 takes the first conflict
    mLastGrant = 1'b1;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
        mBtb[i] = '0;
        mPht[i] = 2'd1;
    end
endfunction

function automatic phtIdxT expPhtIdx(logic s);
    return mPc[s][6:2] ^ mGhr[s];
endfunction

function automatic logic expPredTaken(logic s);
    btbEntryT e;
    e = mBtb[mPc[s][6:2]];
    return e.valid && (e.tag == mPc[s][31:7]) && (e.isJump || (mPht[expPhtIdx(s)] >= 2'd2));
endfunction

function automatic logic expMispredict(resolveT r);
    return r.valid && ((r.isBranch && (r.predTaken != r.taken)) || (r.isJump && !r.predTaken));
endfunction

function automatic addrT expRedirectPc(resolveT r);
    return (r.isJump || r.taken) ? r.target : r.pc + 32'd4;
endfunction

// PC and history of one slot, looked up against the tables before this cycle's write
function automatic void stepSlot(logic s, logic stall, instrT instr, resolveT r);
    logic pt;
    pt = expPredTaken(s);
    if (expMispredict(r)) begin
        mPc[s] = expRedirectPc(r);
        mGhr[s] = '0;
    end else if (!stall) begin
        if (instr[6:0] == OP_BRANCH) begin
            mGhr[s] = {mGhr[s][`GHR_BITS-2:0], pt};
        end
        mPc[s] = pt ? mBtb[mPc[s][6:2]].target : mPc[s] + 32'd4;
    end
endfunction

function automatic void writeTables(resolveT w);
    logic taken;
    taken = w.isJump || w.taken;
    if (taken) begin
        mBtb[w.pc[6:2]] = '{valid: 1'b1, tag: w.pc[31:7], target: w.target, isJump: w.isJump};
    end
    if (w.isBranch) begin
        if (taken && (mPht[w.phtIdx] != 2'd3)) begin
            mPht[w.phtIdx] = mPht[w.phtIdx] + 2'd1;
        end else if (!taken && (mPht[w.phtIdx] != 2'd0)) begin
            mPht[w.phtIdx] = mPht[w.phtIdx] - 2'd1;
        end
    end
endfunction

// One write per cycle, a conflict goes to the slot that did not write last
function automatic void stepTables();
    logic g0;
    logic g1;
    g0 = mBufValid[0] && (!mBufValid[1] || mLastGrant);
    g1 = mBufValid[1] && (!mBufValid[0] || !mLastGrant);
    if (g0) begin
        writeTables(mBuf[0]);
        mBufValid[0] = 1'b0;
        mLastGrant = 1'b0;
    end else if (g1) begin
        writeTables(mBuf[1]);
        mBufValid[1] = 1'b0;
        mLastGrant = 1'b1;
    end
endfunction

function automatic void loadBuffer(logic s, resolveT r);
    if (r.valid && (r.isBranch || r.isJump)) begin
        mBuf[s] = r;
        mBufValid[s] = 1'b1;
    end
endfunction

`endif

//--- verif/dualFetchTb.sv
/*
 * Testbench for the dual fetch front end, every output checked against a cycle model
 */
`timescale 1ns/1ps
`default_nettype none
`include "frontEnd_settings.svh"

module dualFetchTb
    import riscvPkg::*;
    import predictorPkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED_CYCLES = 80;
    localparam int RANDOM_CYCLES = 3000;
    localparam instrT NOP = 32'h0000_0013;

    `include "dualFetchModel.svh"

    logic clk;
    logic reset;
    logic stall [2];
    instrT instrF [2];
    resolveT res [2];
    addrT pcF [2];
    logic predTakenF [2];
    phtIdxT phtIndexF [2];
    logic mispredict [2];
    integer seed;

    dualFetchTop dut_i (
        .clk(clk), .reset(reset),
        .stall0_i(stall[0]), .instrF0_i(instrF[0]),
        .resolveValid0_i(res[0].valid), .resolvePc0_i(res[0].pc),
        .resolveIsBranch0_i(res[0].isBranch), .resolveIsJump0_i(res[0].isJump),
        .resolveTaken0_i(res[0].taken), .resolveTarget0_i(res[0].target),
        .resolvePredTaken0_i(res[0].predTaken), .resolvePhtIndex0_i(res[0].phtIdx),
        .pcF0_o(pcF[0]), .predTakenF0_o(predTakenF[0]),
        .phtIndexF0_o(phtIndexF[0]), .mispredict0_o(mispredict[0]),
        .stall1_i(stall[1]), .instrF1_i(instrF[1]),
        .resolveValid1_i(res[1].valid), .resolvePc1_i(res[1].pc),
        .resolveIsBranch1_i(res[1].isBranch), .resolveIsJump1_i(res[1].isJump),
        .resolveTaken1_i(res[1].taken), .resolveTarget1_i(res[1].target),
        .resolvePredTaken1_i(res[1].predTaken), .resolvePhtIndex1_i(res[1].phtIdx),
        .pcF1_o(pcF[1]), .predTakenF1_o(predTakenF[1]),
        .phtIndexF1_o(phtIndexF[1]), .mispredict1_o(mispredict[1])
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkAddr(string name, addrT got, addrT want);
        if (got !== want) begin
            abortRun($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic checkFlag(string name, logic got, logic want);
        if (got !== want) begin
            abortRun($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic checkPhtIdx(string name, phtIdxT got, phtIdxT want);
        if (got !== want) begin
            abortRun($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic checkSlot(logic s);
        checkAddr($sformatf("pcF%0d", s), pcF[s], mPc[s]);
        checkFlag($sformatf("predTakenF%0d", s), predTakenF[s], expPredTaken(s));
        checkPhtIdx($sformatf("phtIndexF%0d", s), phtIndexF[s], expPhtIdx(s));
        checkFlag($sformatf("mispredict%0d", s), mispredict[s], expMispredict(res[s]));
    endtask

    // Inputs change on the rising edge, so outputs are compared at the falling one
    always @(negedge clk) begin
        if (reset) begin
            resetModel();
        end else begin
            checkSlot(1'b0);
            checkSlot(1'b1);
            stepSlot(1'b0, stall[0], instrF[0], res[0]);
            stepSlot(1'b1, stall[1], instrF[1], res[1]);
            stepTables();
            loadBuffer(1'b0, res[0]);
            loadBuffer(1'b1, res[1]);
        end
    end

    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100) * CLK_PERIOD);
        abortRun("Watchdog expired before the test sequence finished");
    end

    function automatic resolveT makeResolve(addrT pc, logic isBranch, logic isJump,
                                            logic taken, addrT target, logic predTaken,
                                            phtIdxT phtIdx);
        return '{valid: 1'b1, pc: pc, isBranch: isBranch, isJump: isJump, taken: taken,
                 target: target, predTaken: predTaken, phtIdx: phtIdx};
    endfunction

    task automatic idle(int n);
        repeat (n) @(posedge clk);
    endtask

    // One-cycle strobe on both slots, then a quiet cycle to keep the two-cycle spacing
    task automatic pulseResolve(resolveT r0, resolveT r1);
        @(posedge clk);
        res[0] <= r0;
        res[1] <= r1;
        @(posedge clk);
        res[0] <= '0;
        res[1] <= '0;
    endtask

    // A slot that resolved last cycle stays quiet this cycle
    task automatic driveRandom(logic s);
        logic [31:0] rnd;
        logic [31:0] tgt;
        rnd = $random(seed);
        tgt = $random(seed);
        stall[s] <= (rnd[1:0] == 2'b00);
        instrF[s] <= {rnd[31:7], rnd[3] ? OP_BRANCH : (rnd[2] ? OP_JAL : NOP[6:0])};
        if (res[s].valid || rnd[4]) begin
            res[s] <= '0;
        end else begin
            res[s] <= makeResolve({24'd0, rnd[13:8], 2'b00}, ~rnd[5], rnd[5] & ~rnd[6],
                                  rnd[14], {24'd0, tgt[7:2], 2'b00}, rnd[15], rnd[20:16]);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 32'h99ff_06d6;
        stall[0] = 1'b0;
        stall[1] = 1'b0;
        instrF[0] = NOP;
        instrF[1] = NOP;
        res[0] = '0;
        res[1] = '0;
        idle(RESET_CYCLES);
        reset <= 1'b0;
        @(negedge clk);
        checkAddr("pcF0", pcF[0], `RESET_PC0);
        checkAddr("pcF1", pcF[1], `RESET_PC1);

        // Sequential fetch, slot 1 holds while stalled
        idle(4);
        stall[1] <= 1'b1;
        idle(3);
        stall[1] <= 1'b0;

        // Taken self-loop branch at 0x40 trains the BTB and PHT, then a jump returns there
        pulseResolve(makeResolve(32'h40, 1'b1, 1'b0, 1'b1, 32'h40, 1'b0, 5'h10), '0);
        idle(3);
        pulseResolve(makeResolve(32'h104, 1'b0, 1'b1, 1'b1, 32'h40, 1'b0, 5'h0), '0);
        repeat (2) begin
            @(negedge clk);
            checkFlag("predTakenF0", predTakenF[0], 1'b1);
            checkAddr("pcF0", pcF[0], 32'h40);
        end

        // Fill the history, then mispredict under stall
        @(posedge clk);
        instrF[0] <= {25'd0, OP_BRANCH};
        idle(3);
        stall[0] <= 1'b1;
        pulseResolve(makeResolve(32'h40, 1'b1, 1'b0, 1'b0, 32'h80, 1'b1, 5'h10), '0);
        @(negedge clk);
        checkAddr("pcF0", pcF[0], 32'h44);
        checkPhtIdx("phtIndexF0", phtIndexF[0], 5'h11);
        @(posedge clk);
        stall[0] <= 1'b0;
        instrF[0] <= NOP;

        // Both slots write the same BTB entry; slot 0 owned the port last, so it lands second
        pulseResolve(makeResolve(32'h200, 1'b0, 1'b1, 1'b1, 32'h300, 1'b1, 5'h0),
                     makeResolve(32'h200, 1'b0, 1'b1, 1'b1, 32'h400, 1'b1, 5'h0));
        idle(3);
        pulseResolve('0, makeResolve(32'h1084, 1'b1, 1'b0, 1'b1, 32'h200, 1'b0, 5'h0));
        @(negedge clk);
        checkAddr("pcF1", pcF[1], 32'h200);
        checkFlag("predTakenF1", predTakenF[1], 1'b1);
        @(negedge clk);
        checkAddr("pcF1", pcF[1], 32'h300);

        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            driveRandom(1'b0);
            driveRandom(1'b1);
        end
        @(posedge clk);
        res[0] <= '0;
        res[1] <= '0;
        idle(3);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dualFetchTop.sv
/*
 * Dual-slot fetch front end sharing one gshare predictor
 */
`timescale 1ns/1ps
`default_nettype none
`include "frontEnd_settings.svh"

module dualFetchTop
    import riscvPkg::*;
    import predictorPkg::*;
(
    input  wire          clk,
    input  wire          reset,
    // Slot 0
    input  wire          stall0_i,
    input  wire instrT   instrF0_i,
    input  wire          resolveValid0_i,
    input  wire addrT    resolvePc0_i,
    input  wire          resolveIsBranch0_i,
    input  wire          resolveIsJump0_i,
    input  wire          resolveTaken0_i,
    input  wire addrT    resolveTarget0_i,
    input  wire          resolvePredTaken0_i,
    input  wire phtIdxT  resolvePhtIndex0_i,
    output addrT         pcF0_o,
    output logic         predTakenF0_o,
    output phtIdxT       phtIndexF0_o,
    output logic         mispredict0_o,
    // Slot 1
    input  wire          stall1_i,
    input  wire instrT   instrF1_i,
    input  wire          resolveValid1_i,
    input  wire addrT    resolvePc1_i,
    input  wire          resolveIsBranch1_i,
    input  wire          resolveIsJump1_i,
    input  wire          resolveTaken1_i,
    input  wire addrT    resolveTarget1_i,
    input  wire          resolvePredTaken1_i,
    input  wire phtIdxT  resolvePhtIndex1_i,
    output addrT         pcF1_o,
    output logic         predTakenF1_o,
    output phtIdxT       phtIndexF1_o,
    output logic         mispredict1_o
);

    lookupIf look0 ();
    lookupIf look1 ();
    updateIf upd0 ();
    updateIf upd1 ();

    addrT redirectPc0;
    addrT redirectPc1;
    logic writeEn;
    updateT write;

    fetchSlot #(.resetPc(`RESET_PC0)) slot0_i (
        .clk(clk), .reset(reset), .stall_i(stall0_i), .instrF_i(instrF0_i),
        .redirect_i(mispredict0_o), .redirectPc_i(redirectPc0),
        .pcF_o(pcF0_o), .predTakenF_o(predTakenF0_o), .phtIndexF_o(phtIndexF0_o),
        .lookup(look0.slot)
    );

    fetchSlot #(.resetPc(`RESET_PC1)) slot1_i (
        .clk(clk), .reset(reset), .stall_i(stall1_i), .instrF_i(instrF1_i),
        .redirect_i(mispredict1_o), .redirectPc_i(redirectPc1),
        .pcF_o(pcF1_o), .predTakenF_o(predTakenF1_o), .phtIndexF_o(phtIndexF1_o),
        .lookup(look1.slot)
    );

    resolveUnit resolve0_i (
        .clk(clk), .reset(reset), .resolveValid_i(resolveValid0_i),
        .resolvePc_i(resolvePc0_i), .resolveIsBranch_i(resolveIsBranch0_i),
        .resolveIsJump_i(resolveIsJump0_i), .resolveTaken_i(resolveTaken0_i),
        .resolveTarget_i(resolveTarget0_i), .resolvePredTaken_i(resolvePredTaken0_i),
        .resolvePhtIndex_i(resolvePhtIndex0_i), .mispredict_o(mispredict0_o),
        .redirectPc_o(redirectPc0), .update(upd0.requester)
    );

    resolveUnit resolve1_i (
        .clk(clk), .reset(reset), .resolveValid_i(resolveValid1_i),
        .resolvePc_i(resolvePc1_i), .resolveIsBranch_i(resolveIsBranch1_i),
        .resolveIsJump_i(resolveIsJump1_i), .resolveTaken_i(resolveTaken1_i),
        .resolveTarget_i(resolveTarget1_i), .resolvePredTaken_i(resolvePredTaken1_i),
        .resolvePhtIndex_i(resolvePhtIndex1_i), .mispredict_o(mispredict1_o),
        .redirectPc_o(redirectPc1), .update(upd1.requester)
    );

    updateArbiter arbiter_i (
        .clk(clk), .reset(reset), .upd0(upd0.arbiter), .upd1(upd1.arbiter),
        .writeEn_o(writeEn), .write_o(write)
    );

    predictorTables tables_i (
        .clk(clk), .reset(reset), .writeEn_i(writeEn), .write_i(write),
        .look0(look0.tables), .look1(look1.tables)
    );

endmodule

`default_nettype wire

//--- verilog/fetchSlot.sv
/*
 * Fetch slot: PC and global history registers, BTB/PHT lookup, next-PC select
 */
`timescale 1ns/1ps
`default_nettype none
`include "frontEnd_settings.svh"

module fetchSlot
    import riscvPkg::*;
    import predictorPkg::*;
#(
    parameter addrT resetPc = `RESET_PC0
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         stall_i,
    input  wire instrT  instrF_i,
    input  wire         redirect_i,
    input  wire addrT   redirectPc_i,
    output addrT        pcF_o,
    output logic        predTakenF_o,
    output phtIdxT      phtIndexF_o,
    lookupIf.slot       lookup
);

    phtIdxT ghr;
    addrT pcNext;
    logic predTaken;

    // Gshare index: low PC bits folded with the history
    assign lookup.btbIdx = btbIdxOf(pcF_o);
    assign lookup.tag = tagOf(pcF_o);
    assign lookup.phtIdx = phtIdxT'(pcF_o[`GHR_BITS+1:2]) ^ ghr;

    // Jumps in the BTB are always taken, branches follow the counter
    assign predTaken = lookup.hit && (lookup.isJump || (lookup.counter >= counterT'(2)));

    assign predTakenF_o = predTaken;
    assign phtIndexF_o = lookup.phtIdx;

    // Redirect beats stall, the pipeline behind fetch is flushed
    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;
        end else if (stall_i) begin
            pcNext = pcF_o;
        end else if (predTaken) begin
            pcNext = lookup.target;
        end else begin
            pcNext = pcF_o + addrT'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= resetPc;
        end else begin
            pcF_o <= pcNext;
        end
    end

    // History restarts after a misprediction
    always_ff @(posedge clk) begin
        if (reset || redirect_i) begin
            ghr <= '0;
        end else if (!stall_i && isBranchOp(instrF_i)) begin
            ghr <= {ghr[`GHR_BITS-2:0], predTaken};
        end
    end

endmodule

`default_nettype wire

//--- verilog/frontEnd_settings.svh
/*
 * Front-end sizing: predictor table depth, history width, address width, reset PCs
 */
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Entries in both the BTB and the PHT
`define BTB_ENTRIES 32

// Global history width, also the PHT index width
`define GHR_BITS 5

`define XLEN 32

// Start addresses of the two fetch slots
`define RESET_PC0 32'h0000_0000
`define RESET_PC1 32'h0000_1000

`endif

//--- verilog/predictorIf.sv
/*
 * Predictor interfaces: per-slot table lookup and per-slot update request
 */
`timescale 1ns/1ps
`default_nettype none

// Lookup is combinational, tables answer in the same cycle
interface lookupIf import riscvPkg::*, predictorPkg::*; ();
    btbIdxT btbIdx;
    tagT tag;
    phtIdxT phtIdx;
    logic hit;
    addrT target;
    logic isJump;
    counterT counter;

    modport slot (
        output btbIdx, tag, phtIdx,
        input hit, target, isJump, counter
    );

    modport tables (
        input btbIdx, tag, phtIdx,
        output hit, target, isJump, counter
    );
endinterface

// Request holds with a stable payload until granted
interface updateIf import predictorPkg::*; ();
    logic req;
    updateT payload;
    logic grant;

    modport requester (
        output req, payload,
        input grant
    );

    modport arbiter (
        input req, payload,
        output grant
    );
endinterface

`default_nettype wire

//--- verilog/predictorPkg.sv
/*
 * Branch predictor types: BTB entry, 2-bit counter and table update record
 */
`default_nettype none
`include "frontEnd_settings.svh"

package predictorPkg;
    import riscvPkg::*;

    localparam int BTB_IDX_BITS = $clog2(`BTB_ENTRIES);
    // PC bits above the index and the byte offset
    localparam int TAG_BITS = `XLEN - BTB_IDX_BITS - 2;

    typedef logic [BTB_IDX_BITS-1:0] btbIdxT;
    typedef logic [TAG_BITS-1:0] tagT;
    typedef logic [`GHR_BITS-1:0] phtIdxT;
    typedef logic [1:0] counterT;

    // Weakly not taken
    localparam counterT COUNTER_INIT = 2'd1;

    typedef struct packed {
        logic valid;
        tagT tag;
        addrT target;
        logic isJump;
    } btbEntryT;

    typedef struct packed {
        logic btbWe;
        logic phtWe;
        btbIdxT btbIdx;
        tagT tag;
        addrT target;
        logic isJump;
        phtIdxT phtIdx;
        logic taken;
    } updateT;

    function automatic btbIdxT btbIdxOf(addrT pc);
        return pc[BTB_IDX_BITS+1:2];
    endfunction

    function automatic tagT tagOf(addrT pc);
        return pc[`XLEN-1:BTB_IDX_BITS+2];
    endfunction

endpackage

`default_nettype wire

//--- verilog/predictorTables.sv
/*
 * Shared BTB and PHT with two combinational lookup ports and one write port
 */
`timescale 1ns/1ps
`default_nettype none
`include "frontEnd_settings.svh"

module predictorTables
    import predictorPkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         writeEn_i,
    input  wire updateT write_i,
    lookupIf.tables     look0,
    lookupIf.tables     look1
);

    btbEntryT btb [`BTB_ENTRIES];
    counterT pht [`BTB_ENTRIES];

    btbEntryT read0;
    btbEntryT read1;
    btbEntryT newEntry;
    counterT oldCount;
    counterT newCount;

    function automatic logic tagHit(btbEntryT entry, tagT tag);
        return entry.valid && (entry.tag == tag);
    endfunction

    // Read ports see the array before this cycle's write
    assign read0 = btb[look0.btbIdx];
    assign look0.hit = tagHit(read0, look0.tag);
    assign look0.target = read0.target;
    assign look0.isJump = read0.isJump;
    assign look0.counter = pht[look0.phtIdx];

    assign read1 = btb[look1.btbIdx];
    assign look1.hit = tagHit(read1, look1.tag);
    assign look1.target = read1.target;
    assign look1.isJump = read1.isJump;
    assign look1.counter = pht[look1.phtIdx];

    assign newEntry = '{valid: 1'b1, tag: write_i.tag, target: write_i.target,
                        isJump: write_i.isJump};

    // Saturating 2-bit counter step
    assign oldCount = pht[write_i.phtIdx];
    always_comb begin
        if (write_i.taken) begin
            newCount = (oldCount == 2'd3) ? oldCount : oldCount + 2'd1;
        end else begin
            newCount = (oldCount == 2'd0) ? oldCount : oldCount - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btb[i] <= '0;
                pht[i] <= COUNTER_INIT;
            end
        end else if (writeEn_i) begin
            if (write_i.btbWe) begin
                btb[write_i.btbIdx] <= newEntry;
            end
            if (write_i.phtWe) begin
                pht[write_i.phtIdx] <= newCount;
            end
        end
    end

    writeKnown: assert property (@(posedge clk) disable iff (reset)
        writeEn_i |-> (!write_i.btbWe || !$isunknown(newEntry)) &&
                      (!write_i.phtWe || !$isunknown(newCount)));

endmodule

`default_nettype wire

//--- verilog/resolveUnit.sv
/*
 * Resolve unit: checks a branch outcome against its prediction, raises the
 * redirect, and buffers one table update until the arbiter grants it
 */
`timescale 1ns/1ps
`default_nettype none

module resolveUnit
    import riscvPkg::*;
    import predictorPkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          resolveValid_i,
    input  wire addrT    resolvePc_i,
    input  wire          resolveIsBranch_i,
    input  wire          resolveIsJump_i,
    input  wire          resolveTaken_i,
    input  wire addrT    resolveTarget_i,
    input  wire          resolvePredTaken_i,
    input  wire phtIdxT  resolvePhtIndex_i,
    output logic         mispredict_o,
    output addrT         redirectPc_o,
    updateIf.requester   update
);

    logic outcomeTaken;
    logic loadBuf;
    logic reqQ;
    updateT recordD;
    updateT recordQ;

    // A jump always transfers control
    assign outcomeTaken = resolveIsJump_i || resolveTaken_i;
    assign loadBuf = resolveValid_i && (resolveIsBranch_i || resolveIsJump_i);

    assign mispredict_o = resolveValid_i &&
        ((resolveIsBranch_i && (resolvePredTaken_i != resolveTaken_i)) ||
         (resolveIsJump_i && !resolvePredTaken_i));

    assign redirectPc_o = outcomeTaken ? resolveTarget_i : resolvePc_i + addrT'(4);

    always_comb begin
        recordD.btbWe = resolveIsJump_i || (resolveIsBranch_i && resolveTaken_i);
        recordD.phtWe = resolveIsBranch_i;
        recordD.btbIdx = btbIdxOf(resolvePc_i);
        recordD.tag = tagOf(resolvePc_i);
        recordD.target = resolveTarget_i;
        recordD.isJump = resolveIsJump_i;
        recordD.phtIdx = resolvePhtIndex_i;
        recordD.taken = outcomeTaken;
    end

    // A new record may land in the cycle the old one is granted
    always_ff @(posedge clk) begin
        if (reset) begin
            reqQ <= 1'b0;
        end else if (loadBuf) begin
            reqQ <= 1'b1;
        end else if (update.grant) begin
            reqQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadBuf) begin
            recordQ <= recordD;
        end
    end

    assign update.req = reqQ;
    assign update.payload = recordQ;

    // Resolves faster than the arbiter drains would lose an update
    bufferFree: assert property (@(posedge clk) disable iff (reset)
        loadBuf |-> (!reqQ || update.grant));

endmodule

`default_nettype wire

//--- verilog/riscvPkg.sv
/*
 * RISC-V instruction types and the control-flow opcodes seen by fetch
 */
`default_nettype none
`include "frontEnd_settings.svh"

package riscvPkg;

    typedef logic [`XLEN-1:0] addrT;
    typedef logic [31:0] instrT;
    typedef logic [6:0] opcodeT;

    localparam opcodeT OP_BRANCH = 7'b110_0011;
    localparam opcodeT OP_JAL    = 7'b110_1111;
    localparam opcodeT OP_JALR   = 7'b110_0111;

    function automatic opcodeT opcodeOf(instrT instr);
        return instr[6:0];
    endfunction

    function automatic logic isBranchOp(instrT instr);
        return opcodeOf(instr) == OP_BRANCH;
    endfunction

    // Unconditional jumps, direct or register based
    function automatic logic isJumpOp(instrT instr);
        return (opcodeOf(instr) == OP_JAL) || (opcodeOf(instr) == OP_JALR);
    endfunction

endpackage

`default_nettype wire

//--- verilog/updateArbiter.sv
/*
 * Round-robin arbiter for the single predictor table write port
 */
`timescale 1ns/1ps
`default_nettype none

module updateArbiter
    import predictorPkg::*;
(
    input  wire      clk,
    input  wire      reset,
    updateIf.arbiter upd0,
    updateIf.arbiter upd1,
    output logic     writeEn_o,
    output updateT   write_o
);

    // High when slot 1 held the port last
    logic lastGrant;
    logic grant0;
    logic grant1;

    always_comb begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        if (upd0.req && upd1.req) begin
            // Conflict goes to the slot that waited
            grant0 = lastGrant;
            grant1 = !lastGrant;
        end else begin
            grant0 = upd0.req;
            grant1 = upd1.req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lastGrant <= 1'b1;
        end else if (grant0) begin
            lastGrant <= 1'b0;
        end else if (grant1) begin
            lastGrant <= 1'b1;
        end
    end

    assign upd0.grant = grant0;
    assign upd1.grant = grant1;
    assign writeEn_o = grant0 || grant1;
    assign write_o = grant1 ? upd1.payload : upd0.payload;

    // A slot that loses a conflict owns the port in the next cycle
    waitBounded0: assert property (@(posedge clk) disable iff (reset)
        (upd0.req && !upd0.grant) |=> upd0.grant);

    waitBounded1: assert property (@(posedge clk) disable iff (reset)
        (upd1.req && !upd1.grant) |=> upd1.grant);

endmodule

`default_nettype wire
